/* design/muldiv_pkg.sv */
////////////////////////////////////////
// Shared types and constants for the RV32 M-extension unit
// RV32 only, no word forms such as MULW
// md_op_e encoding equals funct3, so decode casts funct3 directly
// Latency values are fixed here and are not module parameters
////////////////////////////////////////

`default_nettype none

package muldiv_pkg;

  ////////////////////////////////////////
  // Widths and latencies
  ////////////////////////////////////////

  // Data and instruction width
  localparam int XLEN = 32;
  localparam int ILEN = 32;

  // Product register stages inside the multiplier
  localparam int MUL_LATENCY = 2;

  // Shift-subtract iterations, one per quotient bit
  localparam int DIV_STEPS = 32;

  // Down counter widths, sized to hold the start value
  localparam int MUL_CNT_W = $clog2(MUL_LATENCY + 1);
  localparam int DIV_CNT_W = $clog2(DIV_STEPS + 1);

  ////////////////////////////////////////
  // Instruction fields
  ////////////////////////////////////////

  // Low two bits of every 32-bit instruction
  localparam logic [1:0] OPC_LEN32 = 2'b11;

  // Major opcode bits [6:2] of register-register ALU ops
  localparam logic [4:0] OPC_OP = 5'b01100;

  // funct7 that selects the M extension
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  ////////////////////////////////////////
  // Operation and request types
  ////////////////////////////////////////

  // Values match funct3
  // Bit 2 splits multiplier from divider
  typedef enum logic [2:0] {
    MD_MUL    = 3'd0,
    MD_MULH   = 3'd1,
    MD_MULHSU = 3'd2,
    MD_MULHU  = 3'd3,
    MD_DIV    = 3'd4,
    MD_DIVU   = 3'd5,
    MD_REM    = 3'd6,
    MD_REMU   = 3'd7
  } md_op_e;

  // Operation plus both source operands, 67 bits
  typedef struct packed {
    md_op_e          op;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
  } md_req_t;

endpackage

`default_nettype wire

/* design/muldiv_decode.sv */
////////////////////////////////////////
// Decode of M-extension ops from the ID stage
// Decode is combinational, go strobes are one cycle wide
// No accept on the first edge after reset release
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module muldiv_decode
  import muldiv_pkg::*;
(
  input  wire             clk,
  input  wire             rstn,
  input  wire  [ILEN-1:0] id_instr,
  input  wire             id_bubble,
  input  wire             ex_stall,
  input  wire             md_stall,
  input  wire  [XLEN-1:0] op_a,
  input  wire  [XLEN-1:0] op_b,
  output md_req_t         req,
  output logic            mul_go,
  output logic            div_go
);

  // Instruction fields
  logic [1:0] len_bits;
  logic [4:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;

  // Decode results
  logic       is_md;
  logic       slot_ok;
  logic       dec_en;

  ////////////////////////////////////////
  // Field extraction
  ////////////////////////////////////////

  assign len_bits = id_instr[1:0];
  assign opcode   = id_instr[6:2];
  assign funct3   = id_instr[14:12];
  assign funct7   = id_instr[31:25];

  // OP major opcode with the MULDIV funct7
  assign is_md = (len_bits == OPC_LEN32) &&
                 (opcode == OPC_OP) &&
                 (funct7 == FUNCT7_MULDIV);

  // Request is packed whether or not it is taken
  assign req = '{op: md_op_e'(funct3), a: op_a, b: op_b};

  ////////////////////////////////////////
  // Accept enable
  ////////////////////////////////////////

  // Goes high one clock after reset release
  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
      dec_en <= 1'b0;
    else
      dec_en <= 1'b1;
  end

  ////////////////////////////////////////
  // Go strobes
  ////////////////////////////////////////

  // Real instruction, pipeline moving, unit idle
  assign slot_ok = dec_en && !id_bubble && !ex_stall && !md_stall && is_md;

  // funct3[2] picks the divider
  assign mul_go = slot_ok && !funct3[2];
  assign div_go = slot_ok &&  funct3[2];

endmodule

`default_nettype wire

/* design/muldiv_mul.sv */
////////////////////////////////////////
// Sign-folding multiplier, MUL/MULH/MULHSU/MULHU
// Result MUL_LATENCY+1 edges after mul_go
// One operation in flight, mul_go must not arrive while stalled
// mul_r is only meaningful while mul_bubble is low
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module muldiv_mul
  import muldiv_pkg::*;
(
  input  wire              clk,
  input  wire              rstn,
  input  wire              mul_go,
  input  wire md_req_t     req,
  output logic             mul_stall,
  output logic             mul_bubble,
  output logic [XLEN-1:0]  mul_r
);

  typedef enum logic {
    MUL_IDLE,
    MUL_WAIT
  } mul_state_e;

  // Control
  mul_state_e           state;
  logic [MUL_CNT_W-1:0] cnt;

  // Folded operands before capture
  logic [XLEN-1:0]      opa_fold;
  logic [XLEN-1:0]      opb_fold;
  logic                 neg_fold;

  // Captured at acceptance
  md_op_e               op_q;
  logic [XLEN-1:0]      opa_q;
  logic [XLEN-1:0]      opb_q;
  logic                 neg_q;

  // Product pipeline and sign corrected product
  logic [2*XLEN-1:0]    prod_q [MUL_LATENCY];
  logic [2*XLEN-1:0]    prod_fix;

  // Magnitude of a two's complement value
  function automatic logic [XLEN-1:0] abs_val(input logic [XLEN-1:0] x);
    abs_val = x[XLEN-1] ? (~x + 1'b1) : x;
  endfunction

  ////////////////////////////////////////
  // Operand folding
  ////////////////////////////////////////

  // Everything becomes one unsigned 32x32 product
  always_comb
  begin
    case (req.op)
      MD_MUL, MD_MULH:
      begin
        // Both signed
        opa_fold = abs_val(req.a);
        opb_fold = abs_val(req.b);
        neg_fold = req.a[XLEN-1] ^ req.b[XLEN-1];
      end
      MD_MULHSU:
      begin
        // Only rs1 signed
        opa_fold = abs_val(req.a);
        opb_fold = req.b;
        neg_fold = req.a[XLEN-1];
      end
      default:
      begin
        // MULHU, plain unsigned
        opa_fold = req.a;
        opb_fold = req.b;
        neg_fold = 1'b0;
      end
    endcase
  end

  // Operand registers, held until the next accept
  always_ff @(posedge clk)
  begin
    if (mul_go)
    begin
      op_q  <= req.op;
      opa_q <= opa_fold;
      opb_q <= opb_fold;
      neg_q <= neg_fold;
    end
  end

  ////////////////////////////////////////
  // Product stages
  ////////////////////////////////////////

  always_ff @(posedge clk)
  begin
    prod_q[0] <= {{XLEN{1'b0}}, opa_q} * {{XLEN{1'b0}}, opb_q};
    for (int i = 1; i < MUL_LATENCY; i++)
      prod_q[i] <= prod_q[i-1];
  end

  // Undo the folding
  assign prod_fix = neg_q ? (~prod_q[MUL_LATENCY-1] + 1'b1) : prod_q[MUL_LATENCY-1];

  // Output register, low word only for MUL
  always_ff @(posedge clk)
  begin
    if (op_q == MD_MUL)
      mul_r <= prod_fix[XLEN-1:0];
    else
      mul_r <= prod_fix[2*XLEN-1:XLEN];
  end

  ////////////////////////////////////////
  // Stall and bubble FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state      <= MUL_IDLE;
      cnt        <= '0;
      mul_stall  <= 1'b0;
      mul_bubble <= 1'b1;
    end
    else
    begin
      // Result valid for a single cycle
      mul_bubble <= 1'b1;
      case (state)
        MUL_IDLE:
        begin
          if (mul_go)
          begin
            state     <= MUL_WAIT;
            cnt       <= MUL_CNT_W'(MUL_LATENCY);
            mul_stall <= 1'b1;
          end
        end
        MUL_WAIT:
        begin
          if (cnt != '0)
            cnt <= cnt - 1'b1;
          else
          begin
            // Output register loads on this same edge
            state      <= MUL_IDLE;
            mul_stall  <= 1'b0;
            mul_bubble <= 1'b0;
          end
        end
        default:
          state <= MUL_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/muldiv_div.sv */
////////////////////////////////////////
// Restoring radix-2 divider, DIV/DIVU/REM/REMU
// Result DIV_STEPS+2 edges after div_go
// Divide by zero and signed overflow follow the RISC-V rules
// div_r is only meaningful while div_bubble is low
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module muldiv_div
  import muldiv_pkg::*;
(
  input  wire              clk,
  input  wire              rstn,
  input  wire              div_go,
  input  wire md_req_t     req,
  output logic             div_stall,
  output logic             div_bubble,
  output logic [XLEN-1:0]  div_r
);

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_FINISH
  } div_state_e;

  // Control
  div_state_e           state;
  logic [DIV_CNT_W-1:0] cnt;

  // Request decode
  logic                 sgn;
  logic [XLEN-1:0]      a_mag;
  logic [XLEN-1:0]      b_mag;

  // Captured at acceptance
  md_op_e               op_q;
  logic [XLEN-1:0]      dividend_q;
  logic [XLEN-1:0]      divisor_q;
  logic                 quo_neg;
  logic                 rem_neg;
  logic                 dbz_q;
  logic                 ovf_q;

  // Partial remainder and quotient
  logic [XLEN-1:0]      rem_q;
  logic [XLEN-1:0]      quo_q;
  logic [XLEN:0]        rem_sh;
  logic [XLEN:0]        diff;

  // Final fixup
  logic [XLEN-1:0]      quo_fix;
  logic [XLEN-1:0]      rem_fix;
  logic [XLEN-1:0]      quo_res;
  logic [XLEN-1:0]      rem_res;

  ////////////////////////////////////////
  // Operand preparation
  ////////////////////////////////////////

  // DIV and REM treat operands as signed
  assign sgn   = (req.op == MD_DIV) || (req.op == MD_REM);
  assign a_mag = (sgn && req.a[XLEN-1]) ? (~req.a + 1'b1) : req.a;
  assign b_mag = (sgn && req.b[XLEN-1]) ? (~req.b + 1'b1) : req.b;

  // One shift-subtract step
  assign rem_sh = {rem_q, quo_q[XLEN-1]};
  assign diff   = rem_sh - {1'b0, divisor_q};

  always_ff @(posedge clk)
  begin
    if (div_go)
    begin
      op_q       <= req.op;
      dividend_q <= req.a;
      divisor_q  <= b_mag;
      // Quotient sign follows both operands, remainder sign the dividend
      quo_neg    <= sgn && (req.a[XLEN-1] ^ req.b[XLEN-1]);
      rem_neg    <= sgn && req.a[XLEN-1];
      dbz_q      <= (req.b == '0);
      ovf_q      <= sgn && (req.a == {1'b1, {(XLEN-1){1'b0}}}) && (req.b == '1);
      rem_q      <= '0;
      quo_q      <= a_mag;
    end
    else if (state == DIV_RUN && cnt != '0)
    begin
      // Keep the difference when it did not go negative
      if (!diff[XLEN])
      begin
        rem_q <= diff[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b1};
      end
      else
      begin
        rem_q <= rem_sh[XLEN-1:0];
        quo_q <= {quo_q[XLEN-2:0], 1'b0};
      end
    end
  end

  ////////////////////////////////////////
  // Sign fixup and special cases
  ////////////////////////////////////////

  assign quo_fix = quo_neg ? (~quo_q + 1'b1) : quo_q;
  assign rem_fix = rem_neg ? (~rem_q + 1'b1) : rem_q;

  always_comb
  begin
    if (dbz_q)
    begin
      // x / 0
      quo_res = '1;
      rem_res = dividend_q;
    end
    else if (ovf_q)
    begin
      // Most negative / -1
      quo_res = dividend_q;
      rem_res = '0;
    end
    else
    begin
      quo_res = quo_fix;
      rem_res = rem_fix;
    end
  end

  always_ff @(posedge clk)
  begin
    if (state == DIV_FINISH)
      div_r <= ((op_q == MD_REM) || (op_q == MD_REMU)) ? rem_res : quo_res;
  end

  ////////////////////////////////////////
  // Stall and bubble FSM
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rstn)
  begin
    if (!rstn)
    begin
      state      <= DIV_IDLE;
      cnt        <= '0;
      div_stall  <= 1'b0;
      div_bubble <= 1'b1;
    end
    else
    begin
      div_bubble <= 1'b1;
      case (state)
        DIV_IDLE:
        begin
          if (div_go)
          begin
            state     <= DIV_RUN;
            cnt       <= DIV_CNT_W'(DIV_STEPS);
            div_stall <= 1'b1;
          end
        end
        DIV_RUN:
        begin
          // One step per cycle until the count runs out
          if (cnt != '0)
            cnt <= cnt - 1'b1;
          else
            state <= DIV_FINISH;
        end
        DIV_FINISH:
        begin
          state      <= DIV_IDLE;
          div_stall  <= 1'b0;
          div_bubble <= 1'b0;
        end
        default:
          state <= DIV_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

/* design/muldiv_unit.sv */
////////////////////////////////////////
// RV32 M-extension execution unit, top level
// One op in flight, md_stall holds the pipeline meanwhile
// md_r valid only while md_bubble is low, zero otherwise
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module muldiv_unit
  import muldiv_pkg::*;
(
  input  wire              clk,
  input  wire              rstn,
  input  wire  [ILEN-1:0]  id_instr,
  input  wire              id_bubble,
  input  wire  [XLEN-1:0]  op_a,
  input  wire  [XLEN-1:0]  op_b,
  input  wire              ex_stall,
  output logic             md_stall,
  output logic             md_bubble,
  output logic [XLEN-1:0]  md_r
);

  // Decoded request and strobes
  md_req_t         req;
  logic            mul_go;
  logic            div_go;

  // Unit returns
  logic            mul_stall;
  logic            mul_bubble;
  logic [XLEN-1:0] mul_r;
  logic            div_stall;
  logic            div_bubble;
  logic [XLEN-1:0] div_r;

  ////////////////////////////////////////
  // Instances
  ////////////////////////////////////////

  muldiv_decode u_decode (
    .clk       (clk),
    .rstn      (rstn),
    .id_instr  (id_instr),
    .id_bubble (id_bubble),
    .ex_stall  (ex_stall),
    .md_stall  (md_stall),
    .op_a      (op_a),
    .op_b      (op_b),
    .req       (req),
    .mul_go    (mul_go),
    .div_go    (div_go)
  );

  muldiv_mul u_mul (
    .clk        (clk),
    .rstn       (rstn),
    .mul_go     (mul_go),
    .req        (req),
    .mul_stall  (mul_stall),
    .mul_bubble (mul_bubble),
    .mul_r      (mul_r)
  );

  muldiv_div u_div (
    .clk        (clk),
    .rstn       (rstn),
    .div_go     (div_go),
    .req        (req),
    .div_stall  (div_stall),
    .div_bubble (div_bubble),
    .div_r      (div_r)
  );

  ////////////////////////////////////////
  // Output merge
  ////////////////////////////////////////

  // Either unit busy stalls the pipe
  assign md_stall  = mul_stall | div_stall;
  assign md_bubble = mul_bubble & div_bubble;

  // Pick whichever unit is presenting
  always_comb
  begin
    if (!mul_bubble)
      md_r = mul_r;
    else if (!div_bubble)
      md_r = div_r;
    else
      md_r = '0;
  end

endmodule

`default_nettype wire

/* test/tb_muldiv.sv */
////////////////////////////////////////
// Self-checking testbench for the RV32 M-extension unit
// Run from the project root so test/muldiv_vectors.txt is found
// Inputs change and outputs are sampled on the falling edge
// A second M op waits in the slot while the unit is busy
////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tb_muldiv
  import muldiv_pkg::*;
();

  // Instruction kinds in the vector file
  localparam int KIND_MD     = 0;
  localparam int KIND_ALU    = 1;
  localparam int KIND_BUBBLE = 2;

  // Wait limits in clock cycles and the random case count
  localparam int RESULT_TIMEOUT = 100;
  localparam int FILTER_CYCLES  = 8;
  localparam int RANDOM_CASES   = 200;

  // DUT ports
  logic        clk;
  logic        rstn;
  logic [31:0] id_instr;
  logic        id_bubble;
  logic [31:0] op_a;
  logic [31:0] op_b;
  logic        ex_stall;
  logic        md_stall;
  logic        md_bubble;
  logic [31:0] md_r;

  // Bookkeeping
  integer seed          = 32'h14455103;
  int     errors        = 0;
  int     tests_passed  = 0;
  int     tests_failed  = 0;
  int     accepted      = 0;
  int     result_cycles = 0;

  muldiv_unit dut (
    .clk       (clk),
    .rstn      (rstn),
    .id_instr  (id_instr),
    .id_bubble (id_bubble),
    .op_a      (op_a),
    .op_b      (op_b),
    .ex_stall  (ex_stall),
    .md_stall  (md_stall),
    .md_bubble (md_bubble),
    .md_r      (md_r)
  );

  ////////////////////////////////////////
  // Clock, watchdog and result monitor
  ////////////////////////////////////////

  // 20 ns period
  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Hard limit on the whole run
  initial
  begin
    #2000000;
    $display("Watchdog expired before the test sequence ended");
    $display("Simulation finished: FAIL");
    $finish;
  end

  // Counts every result cycle on the outputs
  always @(negedge clk)
  begin
    if (rstn && !md_bubble)
      result_cycles = result_cycles + 1;
  end

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected)
    begin
      errors++;
      $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, expected);
    end
  endtask

  task automatic finish_test(input string tag, input int err_before);
    if (errors == err_before)
    begin
      tests_passed++;
      $display("Test %s passed", tag);
    end
    else
    begin
      tests_failed++;
      $display("Test %s failed", tag);
    end
  endtask

  function automatic string slot_label(input logic [2:0] f3, input int kind);
    if (kind == KIND_BUBBLE)
      slot_label = "bubble";
    else if (kind == KIND_ALU)
      slot_label = "ALU op";
    else
    begin
      case (f3)
        3'd0:    slot_label = "MUL";
        3'd1:    slot_label = "MULH";
        3'd2:    slot_label = "MULHSU";
        3'd3:    slot_label = "MULHU";
        3'd4:    slot_label = "DIV";
        3'd5:    slot_label = "DIVU";
        3'd6:    slot_label = "REM";
        default: slot_label = "REMU";
      endcase
    end
  endfunction

  // R-type OP word with rd x3, rs1 x1 and rs2 x2
  function automatic logic [31:0] make_instr(input logic [2:0] f3, input int kind);
    logic [6:0] f7;
    // Plain ALU ops carry funct7 zero
    f7 = (kind == KIND_ALU) ? 7'b0000000 : 7'b0000001;
    make_instr = {f7, 5'd2, 5'd1, f3, 5'd3, 7'b0110011};
  endfunction

  // RISC-V M arithmetic on 64-bit intermediates
  function automatic logic [31:0] expected_result(input logic [2:0] f3,
                                                  input logic [31:0] a,
                                                  input logic [31:0] b);
    logic [63:0] prod_ss;
    logic [63:0] prod_su;
    logic [63:0] prod_uu;
    longint      sa;
    longint      sb;
    logic        div_zero;
    logic        div_ovf;
    logic [31:0] res;
    prod_ss  = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    prod_su  = {{32{a[31]}}, a} * {32'd0, b};
    prod_uu  = {32'd0, a} * {32'd0, b};
    sa       = {{32{a[31]}}, a};
    sb       = {{32{b[31]}}, b};
    div_zero = (b == 32'd0);
    div_ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
    case (f3)
      3'd0: res = prod_ss[31:0];
      3'd1: res = prod_ss[63:32];
      3'd2: res = prod_su[63:32];
      3'd3: res = prod_uu[63:32];
      3'd4:
      begin
        if (div_zero)
          res = 32'hffff_ffff;
        else if (div_ovf)
          res = a;
        else
          res = 32'(sa / sb);
      end
      3'd5:
      begin
        if (div_zero)
          res = 32'hffff_ffff;
        else
          res = a / b;
      end
      3'd6:
      begin
        // Remainder takes the dividend sign
        if (div_zero)
          res = a;
        else if (div_ovf)
          res = 32'd0;
        else
          res = 32'(sa % sb);
      end
      default:
      begin
        if (div_zero)
          res = a;
        else
          res = a % b;
      end
    endcase
    expected_result = res;
  endfunction

  ////////////////////////////////////////
  // One slot through the unit
  ////////////////////////////////////////

  task automatic run_op(input logic [2:0] f3, input int kind, input int hold,
                        input logic [31:0] a, input logic [31:0] b,
                        input logic [31:0] exp_r, input string tag);
    int err_before;
    int exp_lat;
    int edges;
    err_before = errors;
    exp_lat    = f3[2] ? DIV_STEPS + 2 : MUL_LATENCY + 1;
    @(negedge clk);
    id_instr  = make_instr(f3, kind);
    id_bubble = (kind == KIND_BUBBLE);
    op_a      = a;
    op_b      = b;
    ex_stall  = (hold > 0);
    // Nothing may start under back-pressure
    for (int i = 0; i < hold; i++)
    begin
      @(negedge clk);
      check_value({tag, " md_stall under ex_stall"}, 32'(md_stall), 32'd0);
      check_value({tag, " md_bubble under ex_stall"}, 32'(md_bubble), 32'd1);
    end
    ex_stall = 1'b0;
    // Next rising edge is the acceptance edge
    @(negedge clk);
    if (kind == KIND_MD)
    begin
      accepted++;
      edges = 0;
      // Next M op for the other unit waits behind md_stall
      id_instr = make_instr(~f3, KIND_MD);
      op_a     = ~a;
      op_b     = b ^ 32'h0000_00ff;
      while (md_bubble && edges < RESULT_TIMEOUT)
      begin
        check_value({tag, " md_stall while busy"}, 32'(md_stall), 32'd1);
        // ex_stall toggles and must not slow the running op
        ex_stall = edges[0];
        @(negedge clk);
        edges++;
      end
      // Slot empties before the unit can take it
      id_bubble = 1'b1;
      ex_stall  = 1'b0;
      if (md_bubble)
      begin
        $display("Test %s got no result within %0d cycles", tag, RESULT_TIMEOUT);
        errors++;
      end
      else
      begin
        check_value({tag, " latency"}, 32'(edges), 32'(exp_lat));
        check_value({tag, " md_stall on result"}, 32'(md_stall), 32'd0);
        check_value({tag, " md_r"}, md_r, exp_r);
        // Single result cycle
        @(negedge clk);
        check_value({tag, " md_bubble after result"}, 32'(md_bubble), 32'd1);
      end
    end
    else
    begin
      id_bubble = 1'b1;
      // Unit stays idle on a filtered slot
      for (int i = 0; i < FILTER_CYCLES; i++)
      begin
        check_value({tag, " md_stall on filtered slot"}, 32'(md_stall), 32'd0);
        check_value({tag, " md_bubble on filtered slot"}, 32'(md_bubble), 32'd1);
        @(negedge clk);
      end
    end
    finish_test(tag, err_before);
  endtask

  ////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////

  initial
  begin
    int          fd;
    int          n;
    int          vec_no;
    int          err_before;
    int          pick;
    int          v_kind;
    int          v_hold;
    int          r_kind;
    int          r_hold;
    string       line;
    logic [31:0] v_f3;
    logic [31:0] v_a;
    logic [31:0] v_b;
    logic [31:0] v_exp;
    logic [2:0]  r_f3;
    logic [31:0] r_a;
    logic [31:0] r_b;

    // All inputs quiet while reset is held 16 cycles
    rstn      = 1'b0;
    id_instr  = 32'd0;
    id_bubble = 1'b1;
    op_a      = 32'd0;
    op_b      = 32'd0;
    ex_stall  = 1'b0;
    err_before = errors;
    for (int i = 0; i < 16; i++)
    begin
      @(negedge clk);
      check_value("md_stall in reset", 32'(md_stall), 32'd0);
      check_value("md_bubble in reset", 32'(md_bubble), 32'd1);
      check_value("md_r in reset", md_r, 32'd0);
    end
    rstn = 1'b1;
    // Decoder enable comes one edge after release
    for (int i = 0; i < 3; i++)
    begin
      @(negedge clk);
      check_value("md_stall after reset", 32'(md_stall), 32'd0);
      check_value("md_bubble after reset", 32'(md_bubble), 32'd1);
      check_value("md_r after reset", md_r, 32'd0);
    end
    finish_test("reset", err_before);

    // Directed vectors
    fd = $fopen("test/muldiv_vectors.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open test/muldiv_vectors.txt");
      errors++;
    end
    else
    begin
      vec_no = 0;
      while (!$feof(fd))
      begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line[0] != "#")
        begin
          vec_no++;
          n = $sscanf(line, "%h %d %d %h %h %h", v_f3, v_kind, v_hold, v_a, v_b, v_exp);
          if (n == 6)
            run_op(v_f3[2:0], v_kind, v_hold, v_a, v_b, v_exp,
                   $sformatf("vector %0d %s", vec_no, slot_label(v_f3[2:0], v_kind)));
          else
          begin
            $display("Vector line %0d could not be parsed", vec_no);
            errors++;
          end
        end
      end
      $fclose(fd);
    end

    // Random mix with some zero divisors and overflow pairs
    for (int i = 0; i < RANDOM_CASES; i++)
    begin
      r_f3   = 3'($random(seed));
      r_a    = $random(seed);
      r_b    = $random(seed);
      pick   = $random(seed) & 15;
      r_hold = $random(seed) & 3;
      r_kind = KIND_MD;
      if (pick == 0)
        r_b = 32'd0;
      else if (pick == 1)
      begin
        r_a = 32'h8000_0000;
        r_b = 32'hffff_ffff;
      end
      else if (pick == 2)
        r_b = r_b & 32'h0000_00ff;
      else if (pick == 3)
        r_kind = KIND_BUBBLE;
      else if (pick == 4)
        r_kind = KIND_ALU;
      run_op(r_f3, r_kind, r_hold, r_a, r_b, expected_result(r_f3, r_a, r_b),
             $sformatf("random %0d %s", i, slot_label(r_f3, r_kind)));
    end

    // Let the monitor see the last cycles
    repeat (2) @(negedge clk);
    err_before = errors;
    check_value("result cycles vs accepted ops", 32'(result_cycles), 32'(accepted));
    finish_test("result count", err_before);
    $display("Tests passed %0d, failed %0d, accepted ops %0d, result cycles %0d",
             tests_passed, tests_failed, accepted, result_cycles);
    if (errors == 0 && tests_failed == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* test/muldiv_vectors.txt */
# funct3 kind(0 M-ext, 1 other ALU, 2 bubble) ex_stall_hold op_a op_b expected
# funct3 and operands in hex, kind and hold in decimal, expected unused for kinds 1 and 2
0 0 0 00000000 12345678 00000000
0 0 0 00000001 ffffffff ffffffff
0 0 2 ffffffff ffffffff 00000001
0 0 0 80000000 ffffffff 80000000
0 0 0 7fffffff 7fffffff 00000001
1 0 0 7fffffff 7fffffff 3fffffff
1 0 0 ffffffff ffffffff 00000000
1 0 3 80000000 80000000 40000000
1 0 0 80000000 7fffffff c0000000
1 0 0 80000000 ffffffff 00000000
2 0 0 ffffffff ffffffff ffffffff
2 0 0 80000000 ffffffff 80000000
2 0 1 7fffffff ffffffff 7ffffffe
3 0 0 ffffffff ffffffff fffffffe
3 0 0 80000000 80000000 40000000
3 0 0 00000001 ffffffff 00000000
3 0 0 12345678 00010000 00001234
4 0 0 00000014 00000003 00000006
4 0 4 ffffffec 00000003 fffffffa
4 0 0 00000007 00000000 ffffffff
4 0 0 80000000 ffffffff 80000000
4 0 0 80000000 00000001 80000000
5 0 0 ffffffff 00000002 7fffffff
5 0 0 00000005 00000000 ffffffff
5 0 2 80000000 ffffffff 00000000
6 0 0 ffffffec 00000003 fffffffe
6 0 0 00000014 fffffffd 00000002
6 0 0 80000000 ffffffff 00000000
6 0 0 fffffff9 00000000 fffffff9
7 0 0 ffffffff 0000000a 00000005
7 0 5 00000009 00000000 00000009
0 1 0 00000001 00000002 00000000
4 2 0 00000014 00000003 00000000
5 1 3 ffffffff 00000002 00000000
1 2 2 80000000 80000000 00000000

/* files.f */
design/muldiv_pkg.sv
design/muldiv_decode.sv
design/muldiv_mul.sv
design/muldiv_div.sv
design/muldiv_unit.sv
test/tb_muldiv.sv

/* Makefile */
# Verilator simulation of the RV32 M-extension unit

SRCS := $(wildcard design/*.sv test/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_muldiv: files.f $(SRCS)
	verilator --binary --timing --timescale 1ns/10ps -j 0 \
	  --top-module tb_muldiv -f files.f

run: obj_dir/Vtb_muldiv
	./obj_dir/Vtb_muldiv > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Simulation finished: FAIL" sim.log; then \
	  echo "Simulation failed, see sim.log"; \
	  exit 1; \
	fi
	@if ! grep -q "Simulation finished: PASS" sim.log; then \
	  echo "Simulation ended without a result, see sim.log"; \
	  exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
